// ==== design/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

   typedef logic [31:0] rv_instr_t;
   typedef logic [4:0]  reg_idx_t;

   // major opcodes, bits [6:0]
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   // funct3, bits [14:12]
   localparam logic [2:0] F3_ADD   = 3'b000;   // also jalr
   localparam logic [2:0] F3_SLL   = 3'b001;
   localparam logic [2:0] F3_SR    = 3'b101;   // srl and sra
   localparam logic [2:0] F3_XOR   = 3'b100;
   localparam logic [2:0] F3_OR    = 3'b110;
   localparam logic [2:0] F3_AND   = 3'b111;
   localparam logic [2:0] F3_LW_SW = 3'b010;
   localparam logic [2:0] F3_BEQ   = 3'b000;
   localparam logic [2:0] F3_BNE   = 3'b001;

   // funct7, bits [31:25]
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub, srai

   // fixed registers
   localparam reg_idx_t REG_ZERO = 5'd0;
   localparam reg_idx_t REG_RA   = 5'd1;
   localparam reg_idx_t REG_SP   = 5'd2;

   localparam rv_instr_t EBREAK_WORD = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== design/rvc_pkg.sv ====
`default_nettype none

package rvc_pkg;

   import rv32i_pkg::*;

   typedef logic [15:0] rvc_word_t;

   // quadrant, bits [1:0]
   localparam logic [1:0] QUAD0 = 2'b00;
   localparam logic [1:0] QUAD1 = 2'b01;
   localparam logic [1:0] QUAD2 = 2'b10;

   // funct3, bits [15:13], one set per quadrant
   localparam logic [2:0] C0_ADDI4SPN = 3'b000;
   localparam logic [2:0] C0_LW       = 3'b010;
   localparam logic [2:0] C0_SW       = 3'b110;

   localparam logic [2:0] C1_ADDI     = 3'b000;   // c.nop when rd is x0
   localparam logic [2:0] C1_JAL      = 3'b001;
   localparam logic [2:0] C1_LI       = 3'b010;
   localparam logic [2:0] C1_LUI      = 3'b011;   // c.addi16sp when rd is sp
   localparam logic [2:0] C1_MISC_ALU = 3'b100;
   localparam logic [2:0] C1_J        = 3'b101;
   localparam logic [2:0] C1_BEQZ     = 3'b110;
   localparam logic [2:0] C1_BNEZ     = 3'b111;

   localparam logic [2:0] C2_SLLI      = 3'b000;
   localparam logic [2:0] C2_LWSP      = 3'b010;
   localparam logic [2:0] C2_JR_MV_ADD = 3'b100;   // also jalr and ebreak
   localparam logic [2:0] C2_SWSP      = 3'b110;

   // rd', rs1', rs2' select x8..x15
   localparam logic [1:0] CREG_BASE = 2'b01;

   localparam rv_instr_t ILLEGAL_WORD = 32'hFFFF_FFFF;

   typedef struct packed {
      rv_instr_t instr;
      logic      illegal;
   } expand_result_t;

endpackage

`default_nettype wire

// ==== design/rvc_pipe_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvc_pipe_stage #(
   parameter type payload_t = logic
) (
   input  wire logic     clk,
   input  wire logic     arst_n,
   input  wire logic     up_valid,
   output logic          up_ready,
   input  wire payload_t up_data,
   output logic          dn_valid,
   input  wire logic     dn_ready,
   output payload_t      dn_data
);

   // empty slot or the held item leaves this cycle
   assign up_ready = !dn_valid || dn_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dn_valid <= 1'b0;
      end else if (up_ready) begin
         dn_valid <= up_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (up_valid && up_ready) begin
         dn_data <= up_data;
      end
   end

   // a stalled item must not move or vanish
   a_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
      dn_valid && !dn_ready |=> dn_valid)
      else $error("dn_valid dropped while stalled");

   a_data_held: assert property (@(posedge clk) disable iff (!arst_n)
      dn_valid && !dn_ready |=> $stable(dn_data))
      else $error("dn_data changed while stalled");

endmodule

`default_nettype wire

// ==== design/rvc_quadrant0.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvc_quadrant0
   import rv32i_pkg::*;
   import rvc_pkg::*;
(
   input  wire rvc_word_t cinstr,
   output expand_result_t result
);

   logic [9:0] nzuimm;   // c.addi4spn, scaled by 4
   logic [6:0] word_off; // c.lw / c.sw, scaled by 4
   reg_idx_t   rs1_p;
   reg_idx_t   rd_p;     // rd' for loads, rs2' for stores

   assign nzuimm   = {cinstr[10:7], cinstr[12:11], cinstr[5], cinstr[6], 2'b00};
   assign word_off = {cinstr[5], cinstr[12:10], cinstr[6], 2'b00};
   assign rs1_p    = {CREG_BASE, cinstr[9:7]};
   assign rd_p     = {CREG_BASE, cinstr[4:2]};

   always_comb begin
      result = '{instr: ILLEGAL_WORD, illegal: 1'b1};
      case (cinstr[15:13])
         C0_ADDI4SPN: begin
            if (nzuimm != '0) begin   // zero immediate is reserved
               result = '{instr: {2'b00, nzuimm, REG_SP, F3_ADD, rd_p, OPC_OP_IMM},
                          illegal: 1'b0};
            end
         end
         C0_LW: result = '{instr: {5'b00000, word_off, rs1_p, F3_LW_SW, rd_p, OPC_LOAD},
                           illegal: 1'b0};
         C0_SW: result = '{instr: {5'b00000, word_off[6:5], rd_p, rs1_p, F3_LW_SW,
                                   word_off[4:0], OPC_STORE},
                           illegal: 1'b0};
         default: ;   // fp loads/stores and reserved slots
      endcase
   end

endmodule

`default_nettype wire

// ==== design/rvc_quadrant1.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvc_quadrant1
   import rv32i_pkg::*;
   import rvc_pkg::*;
(
   input  wire rvc_word_t cinstr,
   output expand_result_t result
);

   logic [5:0]  imm6;
   logic [11:0] imm12;    // sign-extended ci immediate
   logic [9:0]  sp_imm;   // c.addi16sp, multiple of 16
   logic [11:1] j_off;
   logic [8:1]  b_off;
   reg_idx_t    rd;
   reg_idx_t    rd_p;
   reg_idx_t    rs2_p;
   rv_instr_t   alu_instr;

   assign imm6   = {cinstr[12], cinstr[6:2]};
   assign imm12  = {{6{imm6[5]}}, imm6};
   assign sp_imm = {cinstr[12], cinstr[4:3], cinstr[5], cinstr[2], cinstr[6], 4'b0000};
   assign j_off  = {cinstr[12], cinstr[8], cinstr[10:9], cinstr[6], cinstr[7], cinstr[2],
                    cinstr[11], cinstr[5:3]};
   assign b_off  = {cinstr[12], cinstr[6:5], cinstr[2], cinstr[11:10], cinstr[4:3]};
   assign rd     = cinstr[11:7];
   assign rd_p   = {CREG_BASE, cinstr[9:7]};
   assign rs2_p  = {CREG_BASE, cinstr[4:2]};

   // register-register subgroup, picked by bits [6:5]
   always_comb begin
      case (cinstr[6:5])
         2'b00:   alu_instr = {F7_ALT, rs2_p, rd_p, F3_ADD, rd_p, OPC_OP};   // sub
         2'b01:   alu_instr = {F7_BASE, rs2_p, rd_p, F3_XOR, rd_p, OPC_OP};
         2'b10:   alu_instr = {F7_BASE, rs2_p, rd_p, F3_OR, rd_p, OPC_OP};
         default: alu_instr = {F7_BASE, rs2_p, rd_p, F3_AND, rd_p, OPC_OP};
      endcase
   end

   always_comb begin
      result = '{instr: ILLEGAL_WORD, illegal: 1'b1};
      case (cinstr[15:13])
         C1_ADDI: result = '{instr: {imm12, rd, F3_ADD, rd, OPC_OP_IMM}, illegal: 1'b0};
         C1_LI:   result = '{instr: {imm12, REG_ZERO, F3_ADD, rd, OPC_OP_IMM}, illegal: 1'b0};
         C1_JAL, C1_J: begin   // only bit 15 tells them apart
            result = '{instr: {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                               cinstr[15] ? REG_ZERO : REG_RA, OPC_JAL},
                       illegal: 1'b0};
         end
         C1_LUI: begin
            if (rd == REG_SP) begin
               if (sp_imm != '0) begin
                  result = '{instr: {{2{sp_imm[9]}}, sp_imm, REG_SP, F3_ADD, REG_SP,
                                     OPC_OP_IMM},
                             illegal: 1'b0};
               end
            end else if (imm6 != '0) begin
               result = '{instr: {{14{imm6[5]}}, imm6, rd, OPC_LUI}, illegal: 1'b0};
            end
         end
         C1_MISC_ALU: begin
            case (cinstr[11:10])
               2'b00, 2'b01: begin
                  // shamt[5] set is reserved on rv32
                  if (!cinstr[12]) begin
                     result = '{instr: {cinstr[10] ? F7_ALT : F7_BASE, cinstr[6:2], rd_p,
                                        F3_SR, rd_p, OPC_OP_IMM},
                                illegal: 1'b0};
                  end
               end
               2'b10: result = '{instr: {imm12, rd_p, F3_AND, rd_p, OPC_OP_IMM},
                                 illegal: 1'b0};
               default: begin
                  if (!cinstr[12]) result = '{instr: alu_instr, illegal: 1'b0};   // subw/addw
               end
            endcase
         end
         default: begin   // c.beqz, c.bnez
            result = '{instr: {{3{b_off[8]}}, b_off[8:5], REG_ZERO, rd_p,
                               cinstr[13] ? F3_BNE : F3_BEQ, b_off[4:1], b_off[8], OPC_BRANCH},
                       illegal: 1'b0};
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== design/rvc_quadrant2.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvc_quadrant2
   import rv32i_pkg::*;
   import rvc_pkg::*;
(
   input  wire rvc_word_t cinstr,
   output expand_result_t result
);

   reg_idx_t   rd;         // rd and rs1 share bits [11:7]
   reg_idx_t   rs2;        // also shamt for c.slli
   logic [7:0] lwsp_off;
   logic [7:0] swsp_off;

   assign rd       = cinstr[11:7];
   assign rs2      = cinstr[6:2];
   assign lwsp_off = {cinstr[3:2], cinstr[12], cinstr[6:4], 2'b00};
   assign swsp_off = {cinstr[8:7], cinstr[12:9], 2'b00};

   always_comb begin
      result = '{instr: ILLEGAL_WORD, illegal: 1'b1};
      case (cinstr[15:13])
         C2_SLLI: begin
            if (!cinstr[12]) begin
               result = '{instr: {F7_BASE, rs2, rd, F3_SLL, rd, OPC_OP_IMM}, illegal: 1'b0};
            end
         end
         C2_LWSP: begin
            if (rd != REG_ZERO) begin
               result = '{instr: {4'b0000, lwsp_off, REG_SP, F3_LW_SW, rd, OPC_LOAD},
                          illegal: 1'b0};
            end
         end
         C2_JR_MV_ADD: begin
            if (rs2 != REG_ZERO) begin   // c.mv / c.add
               result = '{instr: {F7_BASE, rs2, cinstr[12] ? rd : REG_ZERO, F3_ADD, rd, OPC_OP},
                          illegal: 1'b0};
            end else if (rd != REG_ZERO) begin   // c.jr / c.jalr
               result = '{instr: {12'h000, rd, F3_ADD, cinstr[12] ? REG_RA : REG_ZERO, OPC_JALR},
                          illegal: 1'b0};
            end else if (cinstr[12]) begin
               result = '{instr: EBREAK_WORD, illegal: 1'b0};
            end
         end
         C2_SWSP: result = '{instr: {4'b0000, swsp_off[7:5], rs2, REG_SP, F3_LW_SW,
                                     swsp_off[4:0], OPC_STORE},
                             illegal: 1'b0};
         default: ;   // fp stack forms not supported
      endcase
   end

endmodule

`default_nettype wire

// ==== design/rvc_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvc_decoder
   import rvc_pkg::*;
(
   input  wire rvc_word_t cinstr,
   output expand_result_t result
);

   expand_result_t q0_result;
   expand_result_t q1_result;
   expand_result_t q2_result;

   rvc_quadrant0 u_quad0 (.cinstr(cinstr), .result(q0_result));
   rvc_quadrant1 u_quad1 (.cinstr(cinstr), .result(q1_result));
   rvc_quadrant2 u_quad2 (.cinstr(cinstr), .result(q2_result));

   always_comb begin
      case (cinstr[1:0])
         QUAD0:   result = q0_result;
         QUAD1:   result = q1_result;
         QUAD2:   result = q2_result;
         default: result = '{instr: ILLEGAL_WORD, illegal: 1'b1};   // 32-bit space
      endcase
   end

   // every expander must pair the flag with the all-ones word
   always_comb begin
      a_illegal_word: assert (!result.illegal || result.instr == ILLEGAL_WORD)
         else $error("illegal flag without ILLEGAL_WORD for %h", cinstr);
   end

endmodule

`default_nettype wire

// ==== design/rvc_expander.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvc_expander
   import rvc_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      arst_n,
   input  wire logic      in_valid,
   output logic           in_ready,
   input  wire rvc_word_t in_instr,
   output logic           out_valid,
   input  wire logic      out_ready,
   output expand_result_t out_result
);

   logic           dec_valid;   // in_stage holds a word
   logic           dec_ready;
   rvc_word_t      dec_instr;
   expand_result_t dec_result;

   rvc_pipe_stage #(.payload_t(rvc_word_t)) in_stage (
      .clk      (clk),
      .arst_n   (arst_n),
      .up_valid (in_valid),
      .up_ready (in_ready),
      .up_data  (in_instr),
      .dn_valid (dec_valid),
      .dn_ready (dec_ready),
      .dn_data  (dec_instr)
   );

   rvc_decoder u_decoder (
      .cinstr (dec_instr),
      .result (dec_result)
   );

   rvc_pipe_stage #(.payload_t(expand_result_t)) out_stage (
      .clk      (clk),
      .arst_n   (arst_n),
      .up_valid (dec_valid),
      .up_ready (dec_ready),
      .up_data  (dec_result),
      .dn_valid (out_valid),
      .dn_ready (out_ready),
      .dn_data  (out_result)
   );

endmodule

`default_nettype wire

// ==== include/rvc_ref_model.svh ====
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

import rv32i_pkg::*;
import rvc_pkg::*;

// fills base-ISA fields from the compressed form, then packs them by format
function automatic expand_result_t ref_expand(input rvc_word_t c);
   logic [31:0]    imm;
   logic [6:0]     opc;
   logic [6:0]     f7;
   logic [2:0]     f3;
   reg_idx_t       rd, rs1, rs2;
   logic           bad;
   expand_result_t res;

   rd  = c[11:7];
   rs1 = c[11:7];
   rs2 = c[6:2];
   f3  = F3_ADD;
   f7  = F7_BASE;
   opc = OPC_OP_IMM;
   imm = {{26{c[12]}}, c[12], c[6:2]};   // ci form, sign extended
   bad = 1'b0;

   case ({c[1:0], c[15:13]})
      {QUAD0, C0_ADDI4SPN}: begin
         rd  = {CREG_BASE, c[4:2]};
         rs1 = REG_SP;
         imm = {22'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
         bad = (imm == '0);
      end
      {QUAD0, C0_LW}, {QUAD0, C0_SW}: begin
         opc = c[15] ? OPC_STORE : OPC_LOAD;
         f3  = F3_LW_SW;
         rd  = {CREG_BASE, c[4:2]};
         rs1 = {CREG_BASE, c[9:7]};
         rs2 = rd;
         imm = {25'b0, c[5], c[12:10], c[6], 2'b00};
      end
      {QUAD1, C1_ADDI}: ;
      {QUAD1, C1_LI}: rs1 = REG_ZERO;
      {QUAD1, C1_JAL}, {QUAD1, C1_J}: begin
         opc = OPC_JAL;
         rd  = c[15] ? REG_ZERO : REG_RA;
         imm = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
      end
      {QUAD1, C1_LUI}: begin
         bad = ({c[12], c[6:2]} == '0);
         if (rd == REG_SP) begin
            imm = {{22{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
         end else begin
            opc = OPC_LUI;
            imm = {{14{c[12]}}, c[12], c[6:2], 12'b0};
         end
      end
      {QUAD1, C1_MISC_ALU}: begin
         rd  = {CREG_BASE, c[9:7]};
         rs1 = rd;
         rs2 = {CREG_BASE, c[4:2]};
         bad = c[12] && (c[11:10] != 2'b10);
         if (c[11:10] == 2'b10) begin
            f3 = F3_AND;
         end else if (!c[11]) begin
            f3  = F3_SR;
            f7  = c[10] ? F7_ALT : F7_BASE;
            imm = {20'b0, f7, c[6:2]};
         end else begin
            opc = OPC_OP;
            f7  = (c[6:5] == 2'b00) ? F7_ALT : F7_BASE;
            f3  = (c[6:5] == 2'b00) ? F3_ADD :
                  (c[6:5] == 2'b01) ? F3_XOR :
                  (c[6:5] == 2'b10) ? F3_OR : F3_AND;
         end
      end
      {QUAD1, C1_BEQZ}, {QUAD1, C1_BNEZ}: begin
         opc = OPC_BRANCH;
         f3  = c[13] ? F3_BNE : F3_BEQ;
         rs1 = {CREG_BASE, c[9:7]};
         rs2 = REG_ZERO;
         imm = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
      end
      {QUAD2, C2_SLLI}: begin
         f3  = F3_SLL;
         imm = {27'b0, c[6:2]};
         bad = c[12];
      end
      {QUAD2, C2_LWSP}: begin
         opc = OPC_LOAD;
         f3  = F3_LW_SW;
         rs1 = REG_SP;
         imm = {24'b0, c[3:2], c[12], c[6:4], 2'b00};
         bad = (rd == REG_ZERO);
      end
      {QUAD2, C2_SWSP}: begin
         opc = OPC_STORE;
         f3  = F3_LW_SW;
         rs1 = REG_SP;
         imm = {24'b0, c[8:7], c[12:9], 2'b00};
      end
      {QUAD2, C2_JR_MV_ADD}: begin
         if (rs2 != REG_ZERO) begin
            opc = OPC_OP;
            rs1 = c[12] ? rd : REG_ZERO;
         end else begin
            opc = OPC_JALR;
            imm = '0;
            bad = (rs1 == REG_ZERO) && !c[12];
            rd  = c[12] ? REG_RA : REG_ZERO;
         end
      end
      default: bad = 1'b1;
   endcase

   case (opc)
      OPC_OP:     res.instr = {f7, rs2, rs1, f3, rd, opc};
      OPC_STORE:  res.instr = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
      OPC_BRANCH: res.instr = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
      OPC_LUI:    res.instr = {imm[31:12], rd, opc};
      OPC_JAL:    res.instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
      default:    res.instr = {imm[11:0], rs1, f3, rd, opc};
   endcase
   if (c == 16'h9002) res.instr = EBREAK_WORD;   // c.ebreak
   res.illegal = bad;
   if (bad) res.instr = ILLEGAL_WORD;
   return res;
endfunction

`endif

// ==== tests/rvc_expander_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvc_expander_tb
   import rv32i_pkg::*;
   import rvc_pkg::*;
();

   `include "rvc_ref_model.svh"

   localparam int unsigned SEED       = 32'h99e3_f073;
   localparam int          N_RANDOM   = 600;
   localparam int          N_DIRECTED = 39;
   localparam int          WAIT_LIMIT = 200;   // cycles per wait loop

   // one of each kept form, plus reserved and quadrant 3 words
   localparam rvc_word_t DIRECTED_WORDS [N_DIRECTED] = '{
      16'h0040, 16'h0000, 16'h4d84, 16'hc5a8, 16'h2000,             // q0, 0000 and fld reserved
      16'h0001, 16'h0505, 16'h3ffd, 16'h557d,                       // nop addi jal li
      16'h6785, 16'h6781, 16'h7139, 16'h6101,                       // lui, addi16sp, zero imm
      16'h8085, 16'h8485, 16'h9085, 16'h9885,                       // srli srai shamt5 andi
      16'h8d09, 16'h8d29, 16'h8d49, 16'h8d69, 16'h9d09,             // sub xor or and subw
      16'hbfed, 16'hc111, 16'hfc75,                                 // j beqz bnez
      16'h0506, 16'h1506, 16'h4512, 16'h4012,                       // slli, lwsp incl x0
      16'h8082, 16'h8002, 16'h852e, 16'h9002, 16'h9582, 16'h952e,   // jr mv ebreak jalr add
      16'hc62a, 16'h2002, 16'hffff, 16'h0003                        // swsp fldsp q3
   };

   logic           clk;
   logic           arst_n = 1'b1;
   logic           in_valid;
   logic           in_ready;
   rvc_word_t      in_instr;
   logic           out_valid;
   logic           out_ready = 1'b1;
   expand_result_t out_result;

   logic           throttle = 1'b0;   // random out_ready when set
   logic           stream_phase;
   rvc_word_t      random_words [N_RANDOM];
   logic           gap_bits [N_RANDOM];
   logic           ready_bits [64];

   expand_result_t sb_q [$];   // expected results in input order
   expand_result_t head_exp;
   logic           head_valid = 1'b0;
   int             accepted_count = 0;
   int             popped_count = 0;
   int             cycle_count = 0;

   rvc_expander dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_instr   (in_instr),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_result (out_result)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // holds the word until the monitor has seen it taken
   task automatic send_word(input rvc_word_t w);
      int target;
      int waited;
      in_valid = 1'b1;
      in_instr = w;
      target   = accepted_count + 1;
      waited   = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (accepted_count != target && waited < WAIT_LIMIT);
      if (accepted_count != target) stop_with_failure("timeout: in_ready never took the word");
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (sb_q.size() != 0 && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (sb_q.size() != 0) stop_with_failure("timeout: pipeline did not drain");
   endtask

   // head of the queue is what the next output must carry
   always @(posedge clk) begin
      cycle_count++;
      if (out_valid && out_ready && sb_q.size() != 0) begin
         void'(sb_q.pop_front());
         popped_count++;
      end
      if (in_valid && in_ready) begin
         sb_q.push_back(ref_expand(in_instr));
         accepted_count++;
      end
      head_valid = (sb_q.size() != 0);
      if (head_valid) head_exp = sb_q[0];
      else head_exp = '0;
   end

   always @(negedge clk) begin
      out_ready <= throttle ? ready_bits[cycle_count[5:0]] : 1'b1;
   end

   a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid && in_ready)
      else stop_with_failure($sformatf("FAILED at %0t ns: out_valid %b in_ready %b in reset",
                                       $time, $sampled(out_valid), $sampled(in_ready)));

   a_after_reset: assert property (@(posedge clk) $rose(arst_n) |=> !out_valid && in_ready)
      else stop_with_failure($sformatf("FAILED at %0t ns: out_valid %b in_ready %b after reset",
                                       $time, $sampled(out_valid), $sampled(in_ready)));

   a_no_extra: assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> head_valid)
      else stop_with_failure("output valid with no word outstanding");

   a_result: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && head_valid |-> out_result == head_exp)
      else stop_with_failure($sformatf("FAILED at %0t ns: got %h/%b, expected %h/%b",
                                       $time, $sampled(out_result.instr),
                                       $sampled(out_result.illegal), $sampled(head_exp.instr),
                                       $sampled(head_exp.illegal)));

   a_illegal_word: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && out_result.illegal |-> out_result.instr == ILLEGAL_WORD)
      else stop_with_failure($sformatf("FAILED at %0t ns: illegal set with instr %h",
                                       $time, $sampled(out_result.instr)));

   a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_result))
      else stop_with_failure($sformatf("FAILED at %0t ns: stalled output moved to %h",
                                       $time, $sampled(out_result.instr)));

   // accept on edge N, transfer on edge N+2
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      stream_phase && in_valid && in_ready |-> ##2 out_valid && out_ready)
      else stop_with_failure($sformatf("FAILED at %0t ns: result not out 2 cycles after input",
                                       $time));

   a_full_rate: assert property (@(posedge clk) disable iff (!arst_n) stream_phase |-> in_ready)
      else stop_with_failure($sformatf("FAILED at %0t ns: in_ready low while streaming", $time));

   initial begin
      int i;
      in_valid     = 1'b0;
      in_instr     = '0;
      stream_phase = 1'b0;
      void'($urandom(SEED));
      for (i = 0; i < N_RANDOM; i++) begin
         random_words[i] = 16'($urandom);
         gap_bits[i]     = ($urandom % 4) == 0;
      end
      for (i = 0; i < 64; i++) begin
         ready_bits[i] = ($urandom % 3) != 0;
      end

      #1 arst_n = 1'b0;   // after time 0 so the async edge is seen
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // back to back with out_ready high
      stream_phase = 1'b1;
      for (i = 0; i < N_DIRECTED; i++) begin
         send_word(DIRECTED_WORDS[i]);
      end
      stream_phase = 1'b0;
      in_valid     = 1'b0;
      wait_drain();

      throttle <= 1'b1;
      for (i = 0; i < N_RANDOM; i++) begin
         if (gap_bits[i]) begin
            in_valid = 1'b0;   // idle cycle
            @(negedge clk);
         end
         send_word(random_words[i]);
      end
      in_valid = 1'b0;
      throttle <= 1'b0;
      wait_drain();

      if (popped_count != accepted_count || accepted_count != N_DIRECTED + N_RANDOM) begin
         stop_with_failure($sformatf("word count wrong: %0d sent, %0d accepted, %0d received",
                                     N_DIRECTED + N_RANDOM, accepted_count, popped_count));
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== rvc_expander.f ====
+incdir+include
design/rv32i_pkg.sv
design/rvc_pkg.sv
design/rvc_pipe_stage.sv
design/rvc_quadrant0.sv
design/rvc_quadrant1.sv
design/rvc_quadrant2.sv
design/rvc_decoder.sv
design/rvc_expander.sv
tests/rvc_expander_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= rvc_expander.f
TB_TOP     ?= rvc_expander_tb
RTL_TOP    ?= rvc_expander
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
